// File: dma_pkg.sv
// dma copy engine shared definitions
// descriptor layout, read FSM states, status record and burst limits
package dma_pkg;

   localparam int ADDR_W      = 32;
   localparam int LENGTH_W    = 16;
   localparam int BURST_LEN_W = 4;
   localparam int PERF_CNTR_W = 32;

   // burst length field holds beats minus one
   localparam int BURST_BEATS = 1 << BURST_LEN_W;
   localparam logic [BURST_LEN_W-1:0] MAX_BURST_LEN = '1;

   typedef struct packed {
      logic [ADDR_W-1:0]   src_addr;
      logic [ADDR_W-1:0]   dst_addr;
      logic [LENGTH_W-1:0] length;
   } t_dma_descriptor;

   // one-hot read states
   typedef enum logic [3:0] {
      IDLE            = 4'b0001,
      ADDR_SETUP      = 4'b0010,
      CP_RSP_TO_FIFO  = 4'b0100,
      WAIT_FOR_WR_RSP = 4'b1000
   } t_rd_state;

   typedef struct packed {
      logic                   busy;
      t_rd_state              rd_state;
      logic [PERF_CNTR_W-1:0] descriptor_count;
      logic [PERF_CNTR_W-1:0] rd_clk_cnt;
      logic [PERF_CNTR_W-1:0] rd_valid_cnt;
   } t_dma_status;

   // zero length runs as a single beat
   function automatic logic [LENGTH_W-1:0] eff_length(input logic [LENGTH_W-1:0] length);
      logic [LENGTH_W-1:0] len;
      len = length;
      if (length == '0) begin
         len = LENGTH_W'(1);
      end
      return len;
   endfunction

endpackage

// File: dma_fifo_if.sv
// fifo connection bundle
// write side, read side and status flags for one queue
`timescale 1ns/10ps

interface dma_fifo_if #(
   parameter type payload_t = logic
) ();

   logic     wr_en;
   payload_t wr_data;
   logic     almost_full;

   logic     rd_en;
   payload_t rd_data;
   logic     empty;

   modport wr_out (
      output wr_en, wr_data,
      input  almost_full
   );

   modport rd_in (
      output rd_en,
      input  rd_data, empty
   );

   modport fifo (
      input  wr_en, wr_data, rd_en,
      output almost_full, rd_data, empty
   );

endinterface

// File: dma_fifo.sv
// synchronous fifo with a configurable payload type
// head word is always visible on rd_data, rd_en pops it
`timescale 1ns/10ps

module dma_fifo #(
   parameter type payload_t          = logic,
   parameter int  DEPTH              = 4,
   parameter int  ALMOST_FULL_MARGIN = 0
)(
   input logic      clk,
   input logic      reset_n,
   dma_fifo_if.fifo fifo
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t            mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                push;
   logic                pop;

   assign push = fifo.wr_en && (count != CNT_W'(DEPTH));
   assign pop  = fifo.rd_en && (count != '0);

   assign fifo.empty       = (count == '0);
   assign fifo.almost_full = (CNT_W'(DEPTH) - count) <= CNT_W'(ALMOST_FULL_MARGIN);
   assign fifo.rd_data     = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= fifo.wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves occupancy unchanged
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: read_src_fsm.sv
// source read state machine
// splits a descriptor into bursts and copies returned beats into the data fifo
`timescale 1ns/10ps

module read_src_fsm #(
   parameter int DATA_W = 32
)(
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           wr_fsm_done,
   dma_fifo_if.rd_in                      desc,
   dma_fifo_if.wr_out                     data,
   output logic                           ar_valid,
   input  logic                           ar_ready,
   output logic [dma_pkg::ADDR_W-1:0]     ar_addr,
   output logic [dma_pkg::BURST_LEN_W-1:0] ar_len,
   input  logic                           r_valid,
   input  logic                           r_last,
   output logic                           r_ready,
   input  logic [DATA_W-1:0]              r_data,
   output dma_pkg::t_rd_state             rd_state,
   output logic                           busy,
   output logic                           beat_accepted,
   output logic                           xfer_start,
   output logic                           descriptor_done
);

   import dma_pkg::*;

   localparam int BURSTS_W    = LENGTH_W - BURST_LEN_W + 1;
   localparam int BURST_BYTES = BURST_BEATS * DATA_W / 8;

   t_rd_state              state;
   t_rd_state              next;
   logic [LENGTH_W-1:0]    len_m1;
   logic [BURSTS_W-1:0]    num_bursts;
   logic [BURSTS_W-1:0]    rlast_cnt;
   logic [BURSTS_W-1:0]    next_idx;
   logic [BURST_LEN_W-1:0] last_len;
   logic [BURST_LEN_W-1:0] next_len;
   logic                   rlast_acc;
   logic                   final_rlast;

   // head stays put until the pop at the end of the descriptor
   assign len_m1     = eff_length(desc.rd_data.length) - 1'b1;
   assign num_bursts = BURSTS_W'(len_m1 >> BURST_LEN_W) + 1'b1;
   assign last_len   = len_m1[BURST_LEN_W-1:0];

   assign rlast_acc   = r_valid && r_ready && r_last;
   assign final_rlast = rlast_acc && ((rlast_cnt + 1'b1) == num_bursts);

   // index of the burst about to be issued
   assign next_idx = (state == IDLE) ? '0 : rlast_cnt + 1'b1;
   assign next_len = (next_idx == (num_bursts - 1'b1)) ? last_len : MAX_BURST_LEN;

   always_comb begin
      next = state;
      unique case (state)
         IDLE: begin
            if (!desc.empty) next = ADDR_SETUP;
         end
         ADDR_SETUP: begin
            if (ar_valid && ar_ready) next = CP_RSP_TO_FIFO;
         end
         CP_RSP_TO_FIFO: begin
            if (final_rlast) next = WAIT_FOR_WR_RSP;
            else if (rlast_acc) next = ADDR_SETUP;
         end
         WAIT_FOR_WR_RSP: begin
            if (wr_fsm_done) next = IDLE;
         end
         default: next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state     <= IDLE;
         ar_valid  <= 1'b0;
         rlast_cnt <= '0;
      end else begin
         state    <= next;
         ar_valid <= (next == ADDR_SETUP);
         if (state == IDLE) begin
            rlast_cnt <= '0;
         end else if (rlast_acc) begin
            rlast_cnt <= rlast_cnt + 1'b1;
         end
      end
   end

   // address and length load on entry to ADDR_SETUP
   always_ff @(posedge clk) begin
      if (next == ADDR_SETUP && state != ADDR_SETUP) begin
         ar_len <= next_len;
         if (state == IDLE) begin
            ar_addr <= desc.rd_data.src_addr;
         end else begin
            ar_addr <= ar_addr + ADDR_W'(BURST_BYTES);
         end
      end
   end

   // data beats go straight into the fifo
   assign r_ready      = (state == CP_RSP_TO_FIFO) && !data.almost_full;
   assign data.wr_en   = r_valid && r_ready;
   assign data.wr_data = r_data;

   assign desc.rd_en      = (state == WAIT_FOR_WR_RSP) && wr_fsm_done;
   assign descriptor_done = desc.rd_en;

   assign rd_state      = state;
   assign busy          = (state != IDLE);
   assign beat_accepted = r_valid && r_ready;
   assign xfer_start    = (state == IDLE) && (next == ADDR_SETUP);

endmodule

// File: dma_perf_cntr.sv
// performance counters for the read path
// busy cycles and accepted beats per descriptor, plus finished descriptor count
`timescale 1ns/10ps

module dma_perf_cntr (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 busy,
   input  logic                 xfer_start,
   input  logic                 beat_accepted,
   input  logic                 descriptor_done,
   output dma_pkg::t_dma_status status
);

   import dma_pkg::*;

   logic [PERF_CNTR_W-1:0] clk_cnt;
   logic [PERF_CNTR_W-1:0] valid_cnt;
   logic [PERF_CNTR_W-1:0] desc_cnt;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clk_cnt   <= '0;
         valid_cnt <= '0;
         desc_cnt  <= '0;
      end else begin
         if (xfer_start) begin
            clk_cnt   <= '0;
            valid_cnt <= '0;
         end else if (busy) begin
            clk_cnt   <= clk_cnt + 1'b1;
            valid_cnt <= valid_cnt + PERF_CNTR_W'(beat_accepted);
         end
         if (descriptor_done) desc_cnt <= desc_cnt + 1'b1;
      end
   end

   // state field comes from the read FSM at the top
   assign status = '{busy: busy, rd_state: t_rd_state'('0), descriptor_count: desc_cnt,
                     rd_clk_cnt: clk_cnt, rd_valid_cnt: valid_cnt};

endmodule

// File: write_dst_fsm.sv
// destination write state machine
// drains the data fifo to the write port and flags the end of each descriptor
`timescale 1ns/10ps

module write_dst_fsm #(
   parameter int DATA_W = 32
)(
   input  logic                       clk,
   input  logic                       reset_n,
   dma_fifo_if.rd_in                  desc,
   dma_fifo_if.rd_in                  data,
   output logic                       w_valid,
   input  logic                       w_ready,
   output logic [dma_pkg::ADDR_W-1:0] w_addr,
   output logic [DATA_W-1:0]          w_data,
   output logic                       w_last,
   output logic                       wr_fsm_done
);

   import dma_pkg::*;

   localparam int BEAT_SHIFT = $clog2(DATA_W / 8);

   typedef enum logic {
      WR_IDLE,
      WR_STREAM
   } t_wr_state;

   t_wr_state           state;
   logic [LENGTH_W-1:0] beat_cnt;
   logic [LENGTH_W-1:0] len;
   logic                beat_taken;

   assign len        = eff_length(desc.rd_data.length);
   assign w_valid    = (state == WR_STREAM) && !data.empty && (beat_cnt < len);
   assign w_data     = data.rd_data;
   assign w_addr     = desc.rd_data.dst_addr + (ADDR_W'(beat_cnt) << BEAT_SHIFT);
   assign w_last     = (beat_cnt == len - 1'b1);
   assign beat_taken = w_valid && w_ready;

   assign data.rd_en = beat_taken;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= WR_IDLE;
         beat_cnt    <= '0;
         wr_fsm_done <= 1'b0;
      end else begin
         wr_fsm_done <= beat_taken && w_last;
         case (state)
            WR_IDLE: begin
               beat_cnt <= '0;
               if (!desc.empty) state <= WR_STREAM;
            end
            WR_STREAM: begin
               // the read side pops the head in the done cycle,
               // so idle sees the next entry
               if (wr_fsm_done) begin
                  state    <= WR_IDLE;
                  beat_cnt <= '0;
               end else if (beat_taken) begin
                  beat_cnt <= beat_cnt + 1'b1;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

endmodule

// File: dma_top.sv
// single channel dma copy engine
// descriptor queue, read and write state machines, data fifo and counters
`timescale 1ns/10ps

module dma_top #(
   parameter int DATA_W     = 32,
   parameter int DESC_DEPTH = 4,
   parameter int DATA_DEPTH = 32
)(
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            desc_valid,
   output logic                            desc_ready,
   input  logic [dma_pkg::ADDR_W-1:0]      desc_src_addr,
   input  logic [dma_pkg::ADDR_W-1:0]      desc_dst_addr,
   input  logic [dma_pkg::LENGTH_W-1:0]    desc_length,
   output logic                            ar_valid,
   input  logic                            ar_ready,
   output logic [dma_pkg::ADDR_W-1:0]      ar_addr,
   output logic [dma_pkg::BURST_LEN_W-1:0] ar_len,
   input  logic                            r_valid,
   output logic                            r_ready,
   input  logic [DATA_W-1:0]               r_data,
   input  logic                            r_last,
   output logic                            w_valid,
   input  logic                            w_ready,
   output logic [dma_pkg::ADDR_W-1:0]      w_addr,
   output logic [DATA_W-1:0]               w_data,
   output logic                            w_last,
   output logic                            busy,
   output dma_pkg::t_rd_state              rd_state,
   output logic [dma_pkg::PERF_CNTR_W-1:0] descriptor_count,
   output logic [dma_pkg::PERF_CNTR_W-1:0] rd_clk_cnt,
   output logic [dma_pkg::PERF_CNTR_W-1:0] rd_valid_cnt
);

   import dma_pkg::*;

   logic        wr_fsm_done;
   logic        rd_busy;
   logic        xfer_start;
   logic        beat_accepted;
   logic        descriptor_done;
   t_rd_state   fsm_state;
   t_dma_status perf_status;
   t_dma_status status;

   dma_fifo_if #(.payload_t(t_dma_descriptor))    desc_if ();
   dma_fifo_if #(.payload_t(logic [DATA_W-1:0])) data_if ();

   // margin of zero makes almost_full the full flag
   assign desc_ready      = !desc_if.almost_full;
   assign desc_if.wr_en   = desc_valid && desc_ready;
   assign desc_if.wr_data = '{src_addr: desc_src_addr, dst_addr: desc_dst_addr,
                              length: desc_length};

   dma_fifo #(.payload_t(t_dma_descriptor), .DEPTH(DESC_DEPTH), .ALMOST_FULL_MARGIN(0))
      u_desc_fifo (.clk(clk), .reset_n(reset_n), .fifo(desc_if.fifo));

   dma_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DATA_DEPTH), .ALMOST_FULL_MARGIN(1))
      u_data_fifo (.clk(clk), .reset_n(reset_n), .fifo(data_if.fifo));

   read_src_fsm #(.DATA_W(DATA_W)) u_rd_fsm (
      .clk(clk), .reset_n(reset_n), .wr_fsm_done(wr_fsm_done),
      .desc(desc_if.rd_in), .data(data_if.wr_out),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_len(ar_len),
      .r_valid(r_valid), .r_last(r_last), .r_ready(r_ready), .r_data(r_data),
      .rd_state(fsm_state), .busy(rd_busy), .beat_accepted(beat_accepted),
      .xfer_start(xfer_start), .descriptor_done(descriptor_done)
   );

   write_dst_fsm #(.DATA_W(DATA_W)) u_wr_fsm (
      .clk(clk), .reset_n(reset_n), .desc(desc_if.rd_in), .data(data_if.rd_in),
      .w_valid(w_valid), .w_ready(w_ready), .w_addr(w_addr), .w_data(w_data),
      .w_last(w_last), .wr_fsm_done(wr_fsm_done)
   );

   dma_perf_cntr u_perf (
      .clk(clk), .reset_n(reset_n), .busy(rd_busy), .xfer_start(xfer_start),
      .beat_accepted(beat_accepted), .descriptor_done(descriptor_done),
      .status(perf_status)
   );

   // read FSM state joins the counter record here
   always_comb begin
      status          = perf_status;
      status.rd_state = fsm_state;
   end

   assign busy             = status.busy;
   assign rd_state         = status.rd_state;
   assign descriptor_count = status.descriptor_count;
   assign rd_clk_cnt       = status.rd_clk_cnt;
   assign rd_valid_cnt     = status.rd_valid_cnt;

endmodule

// File: dma_assert.sv
// handshake checks on the dma top level ports
`timescale 1ns/10ps

module dma_assert #(
   parameter int DATA_W = 32
)(
   input logic                            clk,
   input logic                            reset_n,
   input logic                            ar_valid,
   input logic                            ar_ready,
   input logic [dma_pkg::ADDR_W-1:0]      ar_addr,
   input logic [dma_pkg::BURST_LEN_W-1:0] ar_len,
   input logic                            r_ready,
   input dma_pkg::t_rd_state              rd_state,
   input logic                            w_valid,
   input logic                            w_ready,
   input logic [DATA_W-1:0]               w_data
);

   import dma_pkg::*;

   // address phase holds until accepted
   ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
      else $error("ar_addr or ar_len changed before ar_ready");

   w_hold: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w_data))
      else $error("w_valid dropped or w_data changed before w_ready");

   r_ready_state: assert property (@(posedge clk) disable iff (!reset_n)
      r_ready |-> rd_state == CP_RSP_TO_FIFO)
      else $error("r_ready high outside CP_RSP_TO_FIFO");

   ar_reset: assert property (@(posedge clk) !reset_n |=> !ar_valid)
      else $error("ar_valid high after reset");

endmodule

bind dma_top dma_assert #(.DATA_W(DATA_W)) u_assert (
   .clk(clk), .reset_n(reset_n), .ar_valid(ar_valid), .ar_ready(ar_ready),
   .ar_addr(ar_addr), .ar_len(ar_len), .r_ready(r_ready), .rd_state(rd_state),
   .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data)
);

// File: dma_tb.sv
// directed testbench for the dma copy engine
// source memory model, destination sink and transfer checks
`timescale 1ns/10ps

module dma_tb;

   import dma_pkg::*;

   localparam int DATA_W     = 32;
   localparam int BEAT_BYTES = DATA_W / 8;
   // short, split, back-pressure and the five queued lengths
   localparam int TOTAL_BEATS     = 5 + 40 + 70 + 52;
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic              last;
   } beat_t;

   typedef struct packed {
      logic [ADDR_W-1:0]      addr;
      logic [BURST_LEN_W-1:0] len;
   } burst_t;

   logic                   clk = 1'b0;
   logic                   reset_n;
   logic                   desc_valid, desc_ready, ar_valid, ar_ready;
   logic                   r_valid, r_ready, r_last, w_valid, w_ready, w_last, busy;
   logic [ADDR_W-1:0]      desc_src_addr, desc_dst_addr, ar_addr, w_addr;
   logic [LENGTH_W-1:0]    desc_length;
   logic [BURST_LEN_W-1:0] ar_len;
   logic [DATA_W-1:0]      r_data, w_data;
   t_rd_state              rd_state;
   logic [PERF_CNTR_W-1:0] descriptor_count, rd_clk_cnt, rd_valid_cnt;

   beat_t             exp_beats[$];
   beat_t             got_beats[$];
   burst_t            exp_bursts[$];
   burst_t            got_bursts[$];
   burst_t            pend[$];
   logic [31:0]       lfsr = 32'h347e;
   logic              gaps_en = 1'b0;
   logic              saw_full = 1'b0;
   logic [ADDR_W-1:0] rd_addr = '0;
   int                rd_left = 0;
   int                pushed = 0;
   int                lasts_seen = 0;
   int                value_errs = 0;
   int                other_errs = 0;

   dma_top #(.DATA_W(DATA_W)) u_dut (.*);

   always #50 clk = ~clk;

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [DATA_W-1:0] src_word(input logic [ADDR_W-1:0] addr);
      return DATA_W'(addr ^ 32'hA5A5_0000);
   endfunction

   task automatic check_word(input string name, input logic [ADDR_W-1:0] got, exp);
      if (got !== exp) begin
         value_errs++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input logic [PERF_CNTR_W-1:0] got, exp);
      if (got !== exp) begin
         value_errs++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_len(input string name, input logic [BURST_LEN_W-1:0] got, exp);
      if (got !== exp) begin
         value_errs++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_state(input string name, input t_rd_state got, exp);
      if (got !== exp) begin
         value_errs++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic note_failure(input string what);
      other_errs++;
      $display("error: %s", what);
   endtask

   // called on a falling edge, returns on the falling edge after the push
   task automatic push_desc(input logic [ADDR_W-1:0] src, dst, input int len);
      int bursts;
      desc_valid    = 1'b1;
      desc_src_addr = src;
      desc_dst_addr = dst;
      desc_length   = LENGTH_W'(len);
      while (!desc_ready) begin
         saw_full = 1'b1;
         @(negedge clk);
      end
      @(negedge clk);
      desc_valid = 1'b0;
      pushed++;
      for (int i = 0; i < len; i++) begin
         exp_beats.push_back(beat_t'{addr: dst + ADDR_W'(i * BEAT_BYTES),
                                     data: src_word(src + ADDR_W'(i * BEAT_BYTES)),
                                     last: (i == len - 1)});
      end
      bursts = (len + 15) / 16;
      for (int k = 0; k < bursts; k++) begin
         exp_bursts.push_back(burst_t'{addr: src + ADDR_W'(k * 16 * BEAT_BYTES),
                                       len: (k == bursts - 1) ? BURST_LEN_W'((len - 1) % 16)
                                                              : BURST_LEN_W'(15)});
      end
   endtask

   task automatic finish_descs(input int last_len);
      beat_t  got;
      beat_t  exp;
      burst_t gb;
      burst_t eb;
      while (lasts_seen != pushed) @(posedge clk);
      // done pulse follows the last beat, the pop lands one cycle later
      repeat (2) @(negedge clk);
      if (got_beats.size() != exp_beats.size()) begin
         note_failure($sformatf("destination took %0d beats, expected %0d",
                                got_beats.size(), exp_beats.size()));
      end
      while (got_beats.size() > 0 && exp_beats.size() > 0) begin
         got = got_beats.pop_front();
         exp = exp_beats.pop_front();
         check_word("w_addr", got.addr, exp.addr);
         check_word("w_data", got.data, exp.data);
         if (got.last !== exp.last) begin
            note_failure($sformatf("w_last missing or misplaced at address %h", exp.addr));
         end
      end
      if (got_bursts.size() != exp_bursts.size()) begin
         note_failure($sformatf("source saw %0d bursts, expected %0d",
                                got_bursts.size(), exp_bursts.size()));
      end
      while (got_bursts.size() > 0 && exp_bursts.size() > 0) begin
         gb = got_bursts.pop_front();
         eb = exp_bursts.pop_front();
         check_word("ar_addr", gb.addr, eb.addr);
         check_len("ar_len", gb.len, eb.len);
      end
      got_beats.delete();
      exp_beats.delete();
      got_bursts.delete();
      exp_bursts.delete();
      // counters describe the most recent descriptor
      check_count("descriptor_count", descriptor_count, PERF_CNTR_W'(pushed));
      check_count("rd_valid_cnt", rd_valid_cnt, PERF_CNTR_W'(last_len));
      check_state("rd_state", rd_state, IDLE);
      if (rd_clk_cnt < PERF_CNTR_W'(last_len)) note_failure("rd_clk_cnt below the beat count");
      if (busy) note_failure("busy still high with the engine idle");
   endtask

   task automatic short_copy();
      push_desc(32'h0000_1000, 32'h0008_0000, 5);
      finish_descs(5);
   endtask

   task automatic multi_burst();
      push_desc(32'h0001_0000, 32'h0009_0000, 40);
      finish_descs(40);
   endtask

   task automatic backpressure();
      gaps_en = 1'b1;
      push_desc(32'h0002_0400, 32'h000A_0000, 70);
      finish_descs(70);
      gaps_en = 1'b0;
   endtask

   task automatic queued_descs();
      saw_full = 1'b0;
      push_desc(32'h0003_0000, 32'h000B_0000, 20);
      push_desc(32'h0003_1000, 32'h000B_1000, 3);
      push_desc(32'h0003_2000, 32'h000B_2000, 8);
      push_desc(32'h0003_3000, 32'h000B_3000, 17);
      push_desc(32'h0003_4000, 32'h000B_4000, 4);
      if (!saw_full) note_failure("desc_ready never dropped with a full descriptor queue");
      finish_descs(4);
   endtask

   // outputs are register driven, so a handshake seen here lands on the next rising edge
   always @(negedge clk) begin : bus_models
      burst_t b;
      logic   bit_a;
      if (reset_n === 1'b1) begin
         if (rd_left == 0 && pend.size() > 0) begin
            b       = pend.pop_front();
            rd_addr = b.addr;
            rd_left = int'(b.len) + 1;
         end
         r_valid = (rd_left > 0);
         if (gaps_en) begin
            lfsr    = lfsr_step(lfsr);
            r_valid = r_valid && lfsr[0];
         end
         r_data = src_word(rd_addr);
         r_last = (rd_left == 1);
         if (r_valid && r_ready) begin
            rd_addr = rd_addr + ADDR_W'(BEAT_BYTES);
            rd_left--;
         end
         // sink runs slower than the source so the data fifo fills
         w_ready = 1'b1;
         ar_ready = 1'b1;
         if (gaps_en) begin
            lfsr     = lfsr_step(lfsr);
            bit_a    = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            w_ready  = bit_a && lfsr[0];
            lfsr     = lfsr_step(lfsr);
            ar_ready = lfsr[0];
         end
         if (w_valid && w_ready) begin
            got_beats.push_back(beat_t'{addr: w_addr, data: w_data, last: w_last});
            if (w_last) lasts_seen++;
         end
         if (ar_valid) begin
            check_state("rd_state", rd_state, ADDR_SETUP);
         end
         if (ar_valid && ar_ready) begin
            pend.push_back(burst_t'{addr: ar_addr, len: ar_len});
            got_bursts.push_back(burst_t'{addr: ar_addr, len: ar_len});
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("error: watchdog expired after %0d cycles with transfers pending",
               WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   initial begin
      reset_n       = 1'b0;
      desc_valid    = 1'b0;
      desc_src_addr = '0;
      desc_dst_addr = '0;
      desc_length   = '0;
      ar_ready      = 1'b0;
      r_valid       = 1'b0;
      r_data        = '0;
      r_last        = 1'b0;
      w_ready       = 1'b0;
      repeat (16) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);
      short_copy();
      multi_burst();
      backpressure();
      queued_descs();
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: sim.f
dma_pkg.sv
dma_fifo_if.sv
dma_fifo.sv
read_src_fsm.sv
dma_perf_cntr.sv
write_dst_fsm.sv
dma_top.sv
dma_assert.sv
dma_tb.sv

// File: Bender.yml
package:
  name: dma_copy

sources:
  - dma_pkg.sv
  - dma_fifo_if.sv
  - dma_fifo.sv
  - read_src_fsm.sv
  - dma_perf_cntr.sv
  - write_dst_fsm.sv
  - dma_top.sv
  - target: test
    files:
      - dma_assert.sv
      - dma_tb.sv
